// File: flist.f
+incdir+testbench
verilog/steer_pkg.sv
verilog/fir_7tap.sv
verilog/fir_bank.sv
verilog/steer_combine.sv
verilog/h_steer_filter.sv
testbench/tb_h_steer_filter.sv

// File: testbench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// x^16 + x^14 + x^13 + x^11 + 1, new bit enters at the bottom
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   logic fb;
   fb = s[15] ^ s[13] ^ s[12] ^ s[10];
   return {s[14:0], fb};
endfunction

// channel 0..6 is f1, f2, f3, h1, h2, h3, h4
function automatic int coef_of(input int ch, input int k);
   int row [7];
   case (ch)
      0:       row = '{29, 101, 15, 235, 15, 101, 29};
      1, 4:    row = '{4, 42, 163, 255, 163, 42, 4};
      2:       row = '{12, 77, 148, 0, 148, 77, 12};
      3:       row = '{15, 25, 193, 0, 193, 25, 15};
      default: row = '{9, 56, 109, 0, 109, 56, 9};
   endcase
   return row[k];
endfunction

// tap k sits in bits 16k+15 down to 16k, tap 0 newest
function automatic logic [27:0] fir_ref(input int ch, input logic [111:0] line);
   longint acc;
   acc = 0;
   for (int k = 0; k < 7; k++)
   begin
      acc = acc + longint'(coef_of(ch, k)) * longint'(line[16*k +: 16]);
   end
   return acc[27:0];
endfunction

// 28-bit two's complement to a wide signed value
function automatic longint as_signed(input logic [27:0] v);
   if (v[27])
   begin
      return longint'(v) - 64'd268435456;
   end
   return longint'(v);
endfunction

// bits 30 down to 15 of the sum
function automatic logic [15:0] top_bits(input longint sum);
   return sum[30:15];
endfunction

function automatic steer_out_t steer_ref(input basis_bundle_t b);
   longint f1;
   longint f2;
   longint f3;
   longint h1;
   longint h2;
   longint h3;
   longint h4;
   longint term_f1;
   longint term_f2;
   longint term_h1;
   longint term_h2;
   longint wide_h3;
   longint wide_h4;
   steer_out_t r;
   f1 = as_signed(b.f1);
   f2 = as_signed(b.f2);
   f3 = as_signed(b.f3);
   h1 = as_signed(b.h1);
   h2 = as_signed(b.h2);
   h3 = as_signed(b.h3);
   h4 = as_signed(b.h4);
   // shifts per term, before any adding
   term_f1 = f1 >>> 1;
   term_f2 = f2 >>> 1;
   term_h1 = (h1 >>> 2) + (h1 >>> 3);
   term_h2 = (h2 >>> 2) + (h2 >>> 3);
   wide_h3 = h3 + (h3 >>> 4);
   wide_h4 = h4 + (h4 >>> 4);
   r.re_z = top_bits(f1);
   r.im_z = top_bits(h1);
   r.re_p = top_bits(term_f1 - f3 + term_f2);
   r.im_p = top_bits(term_h1 - wide_h4 + wide_h3 - term_h2);
   r.re_n = top_bits(term_f1 + f3 + term_f2);
   r.im_n = top_bits(term_h1 + wide_h4 + wide_h3 + term_h2);
   return r;
endfunction

`endif

// File: testbench/tb_h_steer_filter.sv
`timescale 1ns/1ps

module tb_h_steer_filter
   import steer_pkg::*;
();

   localparam int NUM_CH      = 7;
   localparam int STREAM_LEN  = 200;
   localparam int GAP_SAMPLES = 60;
   localparam int MAX_GAP     = 7;
   localparam int FULL_LEN    = 10;
   localparam int DRAIN       = 8;
   localparam int TOTAL_CYCLES = 3 + 5 + NUM_CH * NUM_TAPS + STREAM_LEN
                                 + GAP_SAMPLES * (MAX_GAP + 1) + FULL_LEN + DRAIN;

   logic           clk = 1'b0;
   logic           rst_n = 1'b0;
   logic           sample_valid = 1'b0;
   sample_bundle_t samples = '0;
   steer_out_t     result;
   logic           result_valid;

   logic [15:0]  lfsr_state = 16'd22;
   logic [111:0] hist [NUM_CH];
   steer_out_t   exp_q [$];
   int           due_q [$];
   string        name_q [$];
   string        cur_test = "reset";
   int           edge_count = 0;

`include "tb_ref_model.svh"

   h_steer_filter u_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .samples      (samples),
      .result       (result),
      .result_valid (result_valid)
   );

   initial
   begin
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      edge_count <= edge_count + 1;
   end

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [95:0] expected,
                              input logic [95:0] actual);
      if (expected !== actual)
      begin
         stop_with_error($sformatf("mismatch %s expected %0h actual %0h",
                                   name, expected, actual));
      end
   endtask

   // one LFSR step per bit
   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[14:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic logic [111:0] random_bundle();
      logic [111:0] v;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         v[16*ch +: 16] = take_bits(16);
      end
      return v;
   endfunction

   // junk on the bus while idle
   task automatic drive_idle();
      @(negedge clk);
      sample_valid = 1'b0;
      samples      = ~samples;
   endtask

   // f1 is the top field of the bundle
   task automatic drive_sample(input logic [111:0] s);
      basis_bundle_t b;
      @(negedge clk);
      sample_valid = 1'b1;
      samples      = s;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         hist[ch] = {hist[ch][95:0], s[16*(6-ch) +: 16]};
         b[28*(6-ch) +: 28] = fir_ref(ch, hist[ch]);
      end
      exp_q.push_back(steer_ref(b));
      due_q.push_back(edge_count + 5);
      name_q.push_back(cur_test);
   endtask

   // compare on the falling edge, outputs settled
   initial
   begin
      steer_out_t want;
      string      name;
      steer_out_t last_result;
      last_result = '0;
      forever
      begin
         @(negedge clk);
         if (!rst_n)
         begin
            check_value("reset result_valid", 96'd0, 96'(result_valid));
         end
         else if (result_valid)
         begin
            if (exp_q.size() == 0)
            begin
               stop_with_error("result_valid went high with no sample in flight");
            end
            want = exp_q.pop_front();
            name = name_q.pop_front();
            check_value({name, " latency"}, 96'(due_q.pop_front()), 96'(edge_count));
            check_value({name, " re_z"}, 96'(want.re_z), 96'(result.re_z));
            check_value({name, " im_z"}, 96'(want.im_z), 96'(result.im_z));
            check_value({name, " re_p"}, 96'(want.re_p), 96'(result.re_p));
            check_value({name, " im_p"}, 96'(want.im_p), 96'(result.im_p));
            check_value({name, " re_n"}, 96'(want.re_n), 96'(result.re_n));
            check_value({name, " im_n"}, 96'(want.im_n), 96'(result.im_n));
            last_result = result;
         end
         else
         begin
            check_value({cur_test, " hold"}, last_result, result);
         end
      end
   end

   initial
   begin
      #((TOTAL_CYCLES + 20) * 100);
      stop_with_error("watchdog expired, results stopped arriving");
   end

   initial
   begin
      logic [111:0] v;
      int           gap;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         hist[ch] = '0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      cur_test = "idle";
      repeat (5) drive_idle();

      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         cur_test = $sformatf("impulse_%0d", ch);
         v = '0;
         v[16*(6-ch) +: 16] = 16'd1024;
         drive_sample(v);
         repeat (NUM_TAPS - 1) drive_sample('0);
      end

      cur_test = "stream";
      repeat (STREAM_LEN) drive_sample(random_bundle());

      cur_test = "gapped";
      for (int i = 0; i < GAP_SAMPLES; i++)
      begin
         drive_sample(random_bundle());
         gap = int'(take_bits(3));
         repeat (gap) drive_idle();
      end

      cur_test = "full_scale";
      repeat (FULL_LEN) drive_sample({112{1'b1}});

      cur_test = "drain";
      repeat (DRAIN) drive_idle();

      if (exp_q.size() != 0)
      begin
         stop_with_error($sformatf("%0d results never arrived", exp_q.size()));
      end
      else
      begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

// File: verilog/fir_7tap.sv
`timescale 1ns/1ps

module fir_7tap
   import steer_pkg::*;
#(
   parameter filter_id_e FILTER = F1
)
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    sample_valid,
   input  sample_t din,
   output basis_t  dout,
   output logic    dout_valid
);

   // dly[0] is the sample one strobe back
   sample_t dly [NUM_TAPS-1];
   basis_t  mac;

   // unsigned sum, cannot overflow BASIS_W
   always_comb
   begin
      mac = BASIS_W'(din) * BASIS_W'(COEF_TABLE[FILTER][0]);
      for (int k = 1; k < NUM_TAPS; k++)
      begin
         mac = mac + BASIS_W'(dly[k-1]) * BASIS_W'(COEF_TABLE[FILTER][k]);
      end
   end

   // line moves only on a strobe, gaps leave it alone
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dly <= '{default: '0};
      end
      else if (sample_valid)
      begin
         dly[0] <= din;
         for (int k = 1; k < NUM_TAPS-1; k++)
         begin
            dly[k] <= dly[k-1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dout       <= '0;
         dout_valid <= 1'b0;
      end
      else
      begin
         dout_valid <= sample_valid;
         if (sample_valid)
         begin
            dout <= mac;
         end
      end
   end

endmodule

// File: verilog/fir_bank.sv
`timescale 1ns/1ps

module fir_bank
   import steer_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  logic           sample_valid,
   input  sample_bundle_t samples,
   output basis_bundle_t  basis,
   output logic           basis_valid
);

   basis_bundle_t fir_out;
   logic          fir_valid;

   fir_7tap #(.FILTER(F1)) u_fir_f1 (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .din          (samples.f1),
      .dout         (fir_out.f1),
      .dout_valid   (fir_valid)
   );

   // shared strobe, so f1 speaks for all seven
   fir_7tap #(.FILTER(F2)) u_fir_f2 (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .din          (samples.f2),
      .dout         (fir_out.f2),
      .dout_valid   ()
   );

   fir_7tap #(.FILTER(F3)) u_fir_f3 (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .din          (samples.f3),
      .dout         (fir_out.f3),
      .dout_valid   ()
   );

   fir_7tap #(.FILTER(H1)) u_fir_h1 (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .din          (samples.h1),
      .dout         (fir_out.h1),
      .dout_valid   ()
   );

   fir_7tap #(.FILTER(H2)) u_fir_h2 (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .din          (samples.h2),
      .dout         (fir_out.h2),
      .dout_valid   ()
   );

   fir_7tap #(.FILTER(H3)) u_fir_h3 (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .din          (samples.h3),
      .dout         (fir_out.h3),
      .dout_valid   ()
   );

   fir_7tap #(.FILTER(H4)) u_fir_h4 (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .din          (samples.h4),
      .dout         (fir_out.h4),
      .dout_valid   ()
   );

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         basis       <= '0;
         basis_valid <= 1'b0;
      end
      else
      begin
         basis_valid <= fir_valid;
         if (fir_valid)
         begin
            basis <= fir_out;
         end
      end
   end

endmodule

// File: verilog/h_steer_filter.sv
`timescale 1ns/1ps

module h_steer_filter
   import steer_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  logic           sample_valid,
   input  sample_bundle_t samples,
   output steer_out_t     result,
   output logic           result_valid
);

   // one cycle in the filters, one in the capture register
   basis_bundle_t basis;
   logic          basis_valid;

   fir_bank u_bank (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .samples      (samples),
      .basis        (basis),
      .basis_valid  (basis_valid)
   );

   // three more cycles to the result
   steer_combine u_steer (
      .clk          (clk),
      .rst_n        (rst_n),
      .basis        (basis),
      .basis_valid  (basis_valid),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

// File: verilog/steer_combine.sv
`timescale 1ns/1ps

module steer_combine
   import steer_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  basis_bundle_t basis,
   input  logic          basis_valid,
   output steer_out_t    result,
   output logic          result_valid
);

   // basis values read as signed
   logic signed [BASIS_W-1:0] f1_s;
   logic signed [BASIS_W-1:0] f2_s;
   logic signed [BASIS_W-1:0] f3_s;
   logic signed [BASIS_W-1:0] h1_s;
   logic signed [BASIS_W-1:0] h2_s;
   logic signed [BASIS_W-1:0] h3_s;
   logic signed [BASIS_W-1:0] h4_s;

   // stage one, scaled terms
   logic signed [TERM_W-1:0] t_re_z;
   logic signed [TERM_W-1:0] t_im_z;
   logic signed [TERM_W-1:0] t_f1;
   logic signed [TERM_W-1:0] t_f2;
   logic signed [TERM_W-1:0] t_f3;
   logic signed [TERM_W-1:0] t_h1;
   logic signed [TERM_W-1:0] t_h2;
   logic signed [TERM_W-1:0] t_h3;
   logic signed [TERM_W-1:0] t_h4;
   logic                     term_valid;

   // stage two, full width sums
   logic signed [ACC_W-1:0] acc_re_z;
   logic signed [ACC_W-1:0] acc_im_z;
   logic signed [ACC_W-1:0] acc_re_p;
   logic signed [ACC_W-1:0] acc_im_p;
   logic signed [ACC_W-1:0] acc_re_n;
   logic signed [ACC_W-1:0] acc_im_n;
   logic                    acc_valid;

   assign f1_s = signed'(basis.f1);
   assign f2_s = signed'(basis.f2);
   assign f3_s = signed'(basis.f3);
   assign h1_s = signed'(basis.h1);
   assign h2_s = signed'(basis.h2);
   assign h3_s = signed'(basis.h3);
   assign h4_s = signed'(basis.h4);

   // each shift is applied per term before adding
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         t_re_z     <= '0;
         t_im_z     <= '0;
         t_f1       <= '0;
         t_f2       <= '0;
         t_f3       <= '0;
         t_h1       <= '0;
         t_h2       <= '0;
         t_h3       <= '0;
         t_h4       <= '0;
         term_valid <= 1'b0;
      end
      else
      begin
         term_valid <= basis_valid;
         if (basis_valid)
         begin
            t_re_z <= TERM_W'(f1_s);
            t_im_z <= TERM_W'(h1_s);
            t_f1   <= TERM_W'(f1_s >>> 1);
            t_f2   <= TERM_W'(f2_s >>> 1);
            t_f3   <= TERM_W'(f3_s);
            t_h1   <= TERM_W'(h1_s >>> 2) + TERM_W'(h1_s >>> 3);
            t_h2   <= TERM_W'(h2_s >>> 2) + TERM_W'(h2_s >>> 3);
            t_h3   <= TERM_W'(h3_s) + TERM_W'(h3_s >>> 4);
            t_h4   <= TERM_W'(h4_s) + TERM_W'(h4_s >>> 4);
         end
      end
   end

   // positive and negative differ only in the sign of f3, h4 and h2
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         acc_re_z  <= '0;
         acc_im_z  <= '0;
         acc_re_p  <= '0;
         acc_im_p  <= '0;
         acc_re_n  <= '0;
         acc_im_n  <= '0;
         acc_valid <= 1'b0;
      end
      else
      begin
         acc_valid <= term_valid;
         if (term_valid)
         begin
            acc_re_z <= ACC_W'(t_re_z);
            acc_im_z <= ACC_W'(t_im_z);
            acc_re_p <= ACC_W'(t_f1) - ACC_W'(t_f3) + ACC_W'(t_f2);
            acc_im_p <= ACC_W'(t_h1) - ACC_W'(t_h4) + ACC_W'(t_h3) - ACC_W'(t_h2);
            acc_re_n <= ACC_W'(t_f1) + ACC_W'(t_f3) + ACC_W'(t_f2);
            acc_im_n <= ACC_W'(t_h1) + ACC_W'(t_h4) + ACC_W'(t_h3) + ACC_W'(t_h2);
         end
      end
   end

   // keep the top OUT_W bits, held until the next valid sum
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         result       <= '0;
         result_valid <= 1'b0;
      end
      else
      begin
         result_valid <= acc_valid;
         if (acc_valid)
         begin
            result.re_z <= acc_re_z[OUT_SHIFT +: OUT_W];
            result.im_z <= acc_im_z[OUT_SHIFT +: OUT_W];
            result.re_p <= acc_re_p[OUT_SHIFT +: OUT_W];
            result.im_p <= acc_im_p[OUT_SHIFT +: OUT_W];
            result.re_n <= acc_re_n[OUT_SHIFT +: OUT_W];
            result.im_n <= acc_im_n[OUT_SHIFT +: OUT_W];
         end
      end
   end

endmodule

// File: verilog/steer_pkg.sv
package steer_pkg;

   // datapath widths
   localparam int SAMPLE_W  = 16;
   localparam int NUM_TAPS  = 7;
   localparam int COEF_W    = 8;
   localparam int BASIS_W   = 28;
   localparam int TERM_W    = 29;
   localparam int ACC_W     = 31;
   localparam int OUT_W     = 16;
   localparam int OUT_SHIFT = 15;

   // even basis first, then odd basis
   typedef enum logic [2:0]
   {
      F1,
      F2,
      F3,
      H1,
      H2,
      H3,
      H4
   } filter_id_e;

   // tap 0 multiplies the newest sample
   localparam logic [COEF_W-1:0] COEF_TABLE [F1:H4][NUM_TAPS] = '{
      '{8'd29, 8'd101, 8'd15,  8'd235, 8'd15,  8'd101, 8'd29},
      '{8'd4,  8'd42,  8'd163, 8'd255, 8'd163, 8'd42,  8'd4},
      '{8'd12, 8'd77,  8'd148, 8'd0,   8'd148, 8'd77,  8'd12},
      '{8'd15, 8'd25,  8'd193, 8'd0,   8'd193, 8'd25,  8'd15},
      '{8'd4,  8'd42,  8'd163, 8'd255, 8'd163, 8'd42,  8'd4},
      '{8'd9,  8'd56,  8'd109, 8'd0,   8'd109, 8'd56,  8'd9},
      '{8'd9,  8'd56,  8'd109, 8'd0,   8'd109, 8'd56,  8'd9}
   };

   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [BASIS_W-1:0]  basis_t;
   typedef logic [OUT_W-1:0]    out_t;

   // one pixel per channel, all channels share the sample strobe
   typedef struct packed
   {
      sample_t f1;
      sample_t f2;
      sample_t f3;
      sample_t h1;
      sample_t h2;
      sample_t h3;
      sample_t h4;
   } sample_bundle_t;

   // filter results, read as signed by the steering stage
   typedef struct packed
   {
      basis_t f1;
      basis_t f2;
      basis_t f3;
      basis_t h1;
      basis_t h2;
      basis_t h3;
      basis_t h4;
   } basis_bundle_t;

   // zero, positive and negative orientation
   typedef struct packed
   {
      out_t re_z;
      out_t im_z;
      out_t re_p;
      out_t im_p;
      out_t re_n;
      out_t im_n;
   } steer_out_t;

endpackage
